//--- hw/csr_pkg.sv
package csr_pkg;

  localparam int xlen = 32;

  //////////////////////////////////////////////////////////////
  // CSR addresses and opcodes
  //////////////////////////////////////////////////////////////

  typedef enum logic [11:0] {
    addr_mstatus  = 12'h300,
    addr_mtvec    = 12'h305,
    addr_mscratch = 12'h340,
    addr_mepc     = 12'h341,
    addr_mcause   = 12'h342
  } csr_addr_e;

  typedef enum logic [1:0] {
    op_read  = 2'd0,
    op_write = 2'd1,
    op_set   = 2'd2,
    op_clear = 2'd3
  } csr_op_e;

  typedef enum logic [1:0] {
    trap_exception = 2'd0,
    trap_interrupt = 2'd1,
    trap_mret      = 2'd2
  } trap_kind_e;

  //////////////////////////////////////////////////////////////
  // Register layouts
  //////////////////////////////////////////////////////////////

  // Only the two interrupt enable bits exist, the rest read zero
  typedef struct packed {
    logic [23:0] zero_hi;
    logic        mpie;
    logic [2:0]  zero_mid;
    logic        mie;
    logic [2:0]  zero_lo;
  } mstatus_t;

  typedef struct packed {
    logic        irq;
    logic [30:0] code;
  } mcause_t;

  // Mode bit 0 selects vectored interrupts, bit 1 is hardwired to zero
  typedef struct packed {
    logic [29:0] base;
    logic [1:0]  mode;
  } mtvec_t;

  //////////////////////////////////////////////////////////////
  // Port payloads
  //////////////////////////////////////////////////////////////

  typedef struct packed {
    csr_addr_e       addr;
    csr_op_e         op;
    logic [xlen-1:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic [xlen-1:0] rdata;
    logic            illegal;
  } csr_rsp_t;

  typedef struct packed {
    trap_kind_e      kind;
    logic [30:0]     code;
    logic [xlen-1:0] pc;
  } trap_req_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] mepc;
    mcause_t         mcause;
    mstatus_t        mstatus;
  } trap_upd_t;

endpackage

//--- hw/csr_wb_stage.sv
`timescale 1ns/1ps

module csr_wb_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset_i,
  input  logic     kill_i,
  input  logic     hold_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     full_q;
  payload_t data_q;
  logic     in_xfer;
  logic     out_xfer;

  // A killed or held item is never offered downstream
  assign out_valid_o = full_q && !kill_i && !hold_i;
  assign out_data_o  = data_q;
  assign out_xfer    = out_valid_o && out_ready_i;

  // Refill is allowed when empty or when the current item leaves this cycle
  assign in_ready_o = !kill_i && !hold_i && (!full_q || out_ready_i);
  assign in_xfer    = in_valid_i && in_ready_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (kill_i) begin
      full_q <= 1'b0;
    end else if (in_xfer) begin
      full_q <= 1'b1;
    end else if (out_xfer) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      data_q <= in_data_i;
    end
  end

endmodule

//--- hw/csr_trap_ctrl.sv
`timescale 1ns/1ps

module csr_trap_ctrl
  import csr_pkg::*;
(
  input  logic            trap_valid_i,
  input  trap_req_t       trap_i,
  input  mstatus_t        mstatus_i,
  input  mcause_t         mcause_i,
  input  logic [xlen-1:0] mepc_i,
  input  mtvec_t          mtvec_i,
  output trap_upd_t       upd_o,
  output logic            vec_valid_o,
  output logic [xlen-1:0] vec_pc_o
);

  logic [xlen-1:0] base_pc;
  logic [xlen-1:0] vec_offset;

  assign base_pc    = {mtvec_i.base, 2'b00};
  assign vec_offset = {trap_i.code[xlen-3:0], 2'b00};

  //////////////////////////////////////////////////////////////
  // Register updates
  //////////////////////////////////////////////////////////////

  always_comb begin
    upd_o       = '0;
    upd_o.valid = trap_valid_i;
    if (trap_i.kind == trap_mret) begin
      upd_o.mepc         = mepc_i;
      upd_o.mcause       = mcause_i;
      upd_o.mstatus.mie  = mstatus_i.mpie;
      upd_o.mstatus.mpie = 1'b1;
    end else begin
      upd_o.mepc         = trap_i.pc;
      upd_o.mcause.irq   = (trap_i.kind == trap_interrupt);
      upd_o.mcause.code  = trap_i.code;
      // Interrupts are disabled on entry, the old enable is parked in mpie
      upd_o.mstatus.mie  = 1'b0;
      upd_o.mstatus.mpie = mstatus_i.mie;
    end
  end

  //////////////////////////////////////////////////////////////
  // Redirect target
  //////////////////////////////////////////////////////////////

  assign vec_valid_o = trap_valid_i;

  always_comb begin
    if (trap_i.kind == trap_mret) begin
      vec_pc_o = mepc_i;
    end else if (trap_i.kind == trap_interrupt && mtvec_i.mode[0]) begin
      vec_pc_o = base_pc + vec_offset;
    end else begin
      vec_pc_o = base_pc;
    end
  end

endmodule

//--- hw/csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile
  import csr_pkg::*;
#(
  parameter logic [xlen-1:0] RESET_MTVEC = 32'h0000_1000
) (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  csr_req_t        req_i,
  output logic            rsp_valid_o,
  input  logic            rsp_ready_i,
  output csr_rsp_t        rsp_o,
  input  trap_upd_t       upd_i,
  output mstatus_t        mstatus_o,
  output mcause_t         mcause_o,
  output logic [xlen-1:0] mepc_o,
  output mtvec_t          mtvec_o
);

  mstatus_t        mstatus_q;
  mtvec_t          mtvec_q;
  mcause_t         mcause_q;
  logic [xlen-1:0] mepc_q;
  logic [xlen-1:0] mscratch_q;

  logic [xlen-1:0] old_val;
  logic [xlen-1:0] new_val;
  logic [xlen-1:0] wr_val;
  logic            illegal;
  logic            csr_we;

  // Keeps only mie and mpie of a raw mstatus value
  function automatic mstatus_t legal_mstatus(logic [xlen-1:0] val);
    mstatus_t res;
    res      = '0;
    res.mie  = val[3];
    res.mpie = val[7];
    return res;
  endfunction

  //////////////////////////////////////////////////////////////
  // Read selection and write data
  //////////////////////////////////////////////////////////////

  always_comb begin
    illegal = 1'b0;
    case (req_i.addr)
      addr_mstatus:  old_val = mstatus_q;
      addr_mtvec:    old_val = mtvec_q;
      addr_mscratch: old_val = mscratch_q;
      addr_mepc:     old_val = mepc_q;
      addr_mcause:   old_val = mcause_q;
      default: begin
        old_val = '0;
        illegal = 1'b1;
      end
    endcase
  end

  always_comb begin
    case (req_i.op)
      op_write: new_val = req_i.wdata;
      op_set:   new_val = old_val | req_i.wdata;
      op_clear: new_val = old_val & ~req_i.wdata;
      default:  new_val = old_val;
    endcase
  end

  always_comb begin
    wr_val = new_val;
    case (req_i.addr)
      addr_mstatus: wr_val = legal_mstatus(new_val);
      addr_mepc:    wr_val[0] = 1'b0;
      addr_mtvec:   wr_val[1] = 1'b0;
      default:      wr_val = new_val;
    endcase
  end

  // A trap update in the same cycle wins, the CSR item waits behind it
  assign req_ready_o = rsp_ready_i && !upd_i.valid;
  assign rsp_valid_o = req_valid_i && !upd_i.valid;
  assign rsp_o.rdata   = old_val;
  assign rsp_o.illegal = illegal;

  assign csr_we = req_valid_i && req_ready_o && !illegal && (req_i.op != op_read);

  //////////////////////////////////////////////////////////////
  // Register storage
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      mstatus_q  <= '0;
      mtvec_q    <= RESET_MTVEC;
      mcause_q   <= '0;
      mepc_q     <= '0;
      mscratch_q <= '0;
    end else if (upd_i.valid) begin
      mstatus_q <= legal_mstatus(upd_i.mstatus);
      mcause_q  <= upd_i.mcause;
      mepc_q    <= {upd_i.mepc[xlen-1:1], 1'b0};
    end else if (csr_we) begin
      case (req_i.addr)
        addr_mstatus:  mstatus_q  <= wr_val;
        addr_mtvec:    mtvec_q    <= wr_val;
        addr_mscratch: mscratch_q <= wr_val;
        addr_mepc:     mepc_q     <= wr_val;
        addr_mcause:   mcause_q   <= wr_val;
        default:       mscratch_q <= mscratch_q;
      endcase
    end
  end

  assign mstatus_o = mstatus_q;
  assign mcause_o  = mcause_q;
  assign mepc_o    = mepc_q;
  assign mtvec_o   = mtvec_q;

endmodule

//--- hw/csr_unit.sv
`timescale 1ns/1ps

module csr_unit
  import csr_pkg::*;
#(
  parameter logic [xlen-1:0] RESET_MTVEC = 32'h0000_1000
) (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            csr_req_valid_i,
  output logic            csr_req_ready_o,
  input  csr_req_t        csr_req_i,
  output logic            csr_rsp_valid_o,
  input  logic            csr_rsp_ready_i,
  output csr_rsp_t        csr_rsp_o,
  input  logic            trap_valid_i,
  output logic            trap_ready_o,
  input  trap_req_t       trap_i,
  output logic            vec_valid_o,
  output logic [xlen-1:0] vec_pc_o,
  input  logic            kill_i,
  input  logic            halt_i
);

  logic            csr_wb_valid;
  logic            csr_wb_ready;
  csr_req_t        csr_wb_req;
  logic            trap_wb_valid;
  trap_req_t       trap_wb_req;
  trap_upd_t       trap_upd;
  mstatus_t        mstatus;
  mcause_t         mcause;
  logic [xlen-1:0] mepc;
  mtvec_t          mtvec;

  //////////////////////////////////////////////////////////////
  // Writeback slots
  //////////////////////////////////////////////////////////////

  csr_wb_stage #(.payload_t(csr_req_t)) csr_wb_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .kill_i      (kill_i),
    .hold_i      (halt_i),
    .in_valid_i  (csr_req_valid_i),
    .in_ready_o  (csr_req_ready_o),
    .in_data_i   (csr_req_i),
    .out_valid_o (csr_wb_valid),
    .out_ready_i (csr_wb_ready),
    .out_data_o  (csr_wb_req)
  );

  // The trap side never stalls, the fetch unit takes every redirect
  csr_wb_stage #(.payload_t(trap_req_t)) trap_wb_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .kill_i      (kill_i),
    .hold_i      (halt_i),
    .in_valid_i  (trap_valid_i),
    .in_ready_o  (trap_ready_o),
    .in_data_i   (trap_i),
    .out_valid_o (trap_wb_valid),
    .out_ready_i (1'b1),
    .out_data_o  (trap_wb_req)
  );

  //////////////////////////////////////////////////////////////
  // Trap control and register file
  //////////////////////////////////////////////////////////////

  csr_trap_ctrl trap_ctrl_i (
    .trap_valid_i (trap_wb_valid),
    .trap_i       (trap_wb_req),
    .mstatus_i    (mstatus),
    .mcause_i     (mcause),
    .mepc_i       (mepc),
    .mtvec_i      (mtvec),
    .upd_o        (trap_upd),
    .vec_valid_o  (vec_valid_o),
    .vec_pc_o     (vec_pc_o)
  );

  csr_regfile #(.RESET_MTVEC(RESET_MTVEC)) regfile_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_valid_i (csr_wb_valid),
    .req_ready_o (csr_wb_ready),
    .req_i       (csr_wb_req),
    .rsp_valid_o (csr_rsp_valid_o),
    .rsp_ready_i (csr_rsp_ready_i),
    .rsp_o       (csr_rsp_o),
    .upd_i       (trap_upd),
    .mstatus_o   (mstatus),
    .mcause_o    (mcause),
    .mepc_o      (mepc),
    .mtvec_o     (mtvec)
  );

endmodule

//--- bench/csr_unit_chk.sv
`timescale 1ns/1ps

module csr_unit_chk
  import csr_pkg::*;
(
  input logic            clk,
  input logic            reset_i,
  input logic            kill_i,
  input logic            halt_i,
  input logic            wb_valid_i,
  input logic            wb_ready_i,
  input csr_req_t        wb_req_i,
  input trap_upd_t       upd_i,
  input mstatus_t        mstatus_i,
  input mcause_t         mcause_i,
  input logic [xlen-1:0] mepc_i,
  input mtvec_t          mtvec_i
);

  logic zero_mask_op;

  assign zero_mask_op = wb_valid_i && wb_ready_i && !upd_i.valid && wb_req_i.wdata == '0 &&
                        (wb_req_i.op == op_set || wb_req_i.op == op_clear);

  // Writeback is frozen or flushed, so no register may move at the next edge
  assert property (@(posedge clk) disable iff (reset_i)
    (kill_i || halt_i) |=> $stable({mstatus_i, mcause_i, mepc_i, mtvec_i}))
    else $error("register changed while writeback was killed or halted");

  assert property (@(posedge clk) disable iff (reset_i)
    zero_mask_op |=> $stable({mstatus_i, mcause_i, mepc_i, mtvec_i}))
    else $error("set or clear with zero data changed a register");

  // Both trap fields land on the same edge
  assert property (@(posedge clk) disable iff (reset_i)
    upd_i.valid |=> (mcause_i == $past(upd_i.mcause)) && (mstatus_i == $past(upd_i.mstatus)))
    else $error("trap update did not write mstatus and mcause together");

endmodule

bind csr_unit csr_unit_chk chk_i (
  .clk        (clk),
  .reset_i    (reset_i),
  .kill_i     (kill_i),
  .halt_i     (halt_i),
  .wb_valid_i (csr_wb_valid),
  .wb_ready_i (csr_wb_ready),
  .wb_req_i   (csr_wb_req),
  .upd_i      (trap_upd),
  .mstatus_i  (mstatus),
  .mcause_i   (mcause),
  .mepc_i     (mepc),
  .mtvec_i    (mtvec)
);

//--- bench/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb
  import csr_pkg::*;
();

  logic clk, reset_i, kill_i, halt_i;
  logic csr_req_valid_i, csr_req_ready_o, csr_rsp_valid_o, csr_rsp_ready_i;
  logic trap_valid_i, trap_ready_o, vec_valid_o;
  logic [31:0] vec_pc_o;
  csr_req_t  csr_req_i;
  csr_rsp_t  csr_rsp_o;
  trap_req_t trap_i;

  integer seed = 39;
  int cycles = 0;
  int low_run = 0;
  int mism_cnt = 0;
  int other_cnt = 0;
  int rnd;
  int ready_rnd;
  logic [31:0] m_mstatus, m_mtvec, m_mscratch, m_mepc, m_mcause;
  logic [31:0] exp_rdata[$];
  logic        exp_ill[$];
  logic [31:0] exp_vec[$];

  csr_unit #(.RESET_MTVEC(32'h0000_1000)) csr_unit_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic void model_csr(input logic [11:0] addr, input logic [1:0] op,
                                    input logic [31:0] wdata);
    logic [31:0] old;
    logic [31:0] nv;
    logic        ill;
    ill = 1'b0;
    case (addr)
      addr_mstatus:  old = m_mstatus;
      addr_mtvec:    old = m_mtvec;
      addr_mscratch: old = m_mscratch;
      addr_mepc:     old = m_mepc;
      addr_mcause:   old = m_mcause;
      default: begin
        old = 32'h0;
        ill = 1'b1;
      end
    endcase
    case (op)
      op_write: nv = wdata;
      op_set:   nv = old | wdata;
      op_clear: nv = old & ~wdata;
      default:  nv = old;
    endcase
    exp_rdata.push_back(old);
    exp_ill.push_back(ill);
    if (!ill && op != op_read) begin
      case (addr)
        addr_mstatus:  m_mstatus = nv & 32'h0000_0088;
        addr_mtvec:    m_mtvec = nv & ~32'h2;
        addr_mscratch: m_mscratch = nv;
        addr_mepc:     m_mepc = nv & ~32'h1;
        default:       m_mcause = nv;
      endcase
    end
  endfunction

  function automatic void model_trap(input logic [1:0] kind, input logic [30:0] code,
                                     input logic [31:0] pc);
    logic [31:0] vec;
    if (kind == trap_mret) begin
      exp_vec.push_back(m_mepc);
      m_mstatus = {24'h0, 1'b1, 3'b000, m_mstatus[7], 3'b000};
    end else begin
      vec = m_mtvec & ~32'h3;
      if (kind == trap_interrupt && m_mtvec[0]) vec = vec + {code[29:0], 2'b00};
      exp_vec.push_back(vec);
      m_mepc = pc & ~32'h1;
      m_mcause = {kind == trap_interrupt, code};
      m_mstatus = {24'h0, m_mstatus[3], 3'b000, 1'b0, 3'b000};
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Comparison, back-pressure and timeout
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!reset_i && csr_rsp_valid_o && csr_rsp_ready_i) begin
      if (exp_rdata.size() == 0) begin
        $display("error at %0t: response arrived with no request pending", $time);
        other_cnt++;
      end else begin
        if (csr_rsp_o.rdata !== exp_rdata[0] || csr_rsp_o.illegal !== exp_ill[0]) begin
          $display("mismatch at %0t: response %h/%b, expected %h/%b", $time,
                   csr_rsp_o.rdata, csr_rsp_o.illegal, exp_rdata[0], exp_ill[0]);
          mism_cnt++;
        end
        void'(exp_rdata.pop_front());
        void'(exp_ill.pop_front());
      end
    end
    if (!reset_i && vec_valid_o) begin
      if (exp_vec.size() == 0) begin
        $display("error at %0t: redirect with no trap pending", $time);
        other_cnt++;
      end else begin
        if (vec_pc_o !== exp_vec[0]) begin
          $display("mismatch at %0t: redirect %h, expected %h", $time, vec_pc_o, exp_vec[0]);
          mism_cnt++;
        end
        void'(exp_vec.pop_front());
      end
    end
  end

  // Ready is forced high after three low cycles in a row
  always @(posedge clk) begin
    if (low_run >= 3) begin
      csr_rsp_ready_i <= 1'b1;
      low_run = 0;
    end else begin
      ready_rnd = $random(seed);
      csr_rsp_ready_i <= (ready_rnd[1:0] != 2'b00);
      low_run = (ready_rnd[1:0] != 2'b00) ? 0 : low_run + 1;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles == 3000) begin
      $display("timeout: the run did not finish within 3000 cycles");
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic send_csr(input logic [11:0] addr, input logic [1:0] op,
                          input logic [31:0] wdata);
    @(posedge clk);
    csr_req_valid_i <= 1'b1;
    csr_req_i <= csr_req_t'({addr, op, wdata});
    do @(posedge clk); while (!csr_req_ready_o);
    csr_req_valid_i <= 1'b0;
  endtask

  task automatic drain();
    while (exp_rdata.size() != 0 || exp_vec.size() != 0) @(negedge clk);
  endtask

  task automatic do_csr(input logic [11:0] addr, input logic [1:0] op,
                        input logic [31:0] wdata);
    model_csr(addr, op, wdata);
    send_csr(addr, op, wdata);
    drain();
  endtask

  task automatic do_trap(input logic [1:0] kind, input logic [30:0] code,
                         input logic [31:0] pc);
    model_trap(kind, code, pc);
    @(posedge clk);
    trap_valid_i <= 1'b1;
    trap_i <= trap_req_t'({kind, code, pc});
    do @(posedge clk); while (!trap_ready_o);
    trap_valid_i <= 1'b0;
    drain();
  endtask

  task automatic read_all();
    do_csr(addr_mstatus, op_read, 32'h0);
    do_csr(addr_mtvec, op_read, 32'h0);
    do_csr(addr_mscratch, op_read, 32'h0);
    do_csr(addr_mepc, op_read, 32'h0);
    do_csr(addr_mcause, op_read, 32'h0);
  endtask

  initial begin
    logic [11:0] addr_tab [8];
    addr_tab = '{12'h300, 12'h305, 12'h340, 12'h341, 12'h342, 12'h7c0, 12'h340, 12'h300};
    reset_i = 1'b1;
    kill_i = 1'b0;
    halt_i = 1'b0;
    csr_req_valid_i = 1'b0;
    csr_req_i = '0;
    csr_rsp_ready_i = 1'b1;
    trap_valid_i = 1'b0;
    trap_i = '0;
    {m_mstatus, m_mscratch, m_mepc, m_mcause} = '0;
    m_mtvec = 32'h0000_1000;
    repeat (3) @(posedge clk);
    reset_i <= 1'b0;

    read_all();
    do_csr(12'h7c0, op_write, 32'hdead_beef);
    read_all();
    do_csr(addr_mstatus, op_write, 32'hffff_ffff);
    do_csr(addr_mepc, op_write, 32'h0000_0123);
    do_trap(trap_exception, 31'd2, 32'h0000_0456);
    do_trap(trap_interrupt, 31'd3, 32'h0000_0800);
    do_csr(addr_mtvec, op_write, 32'h0000_2003);
    do_csr(addr_mstatus, op_set, 32'h0000_0008);
    do_trap(trap_interrupt, 31'd5, 32'h0000_0900);
    do_trap(trap_mret, 31'd0, 32'h0);
    read_all();

    // Set and clear with zero data must leave the register as it was
    do_csr(addr_mtvec, op_set, 32'h0);
    do_csr(addr_mepc, op_clear, 32'h0);
    do_csr(addr_mstatus, op_clear, 32'h0);

    // Killed request leaves no response and no write
    send_csr(addr_mepc, op_write, 32'h1234_5678);
    kill_i <= 1'b1;
    @(posedge clk);
    kill_i <= 1'b0;
    do_csr(addr_mepc, op_read, 32'h0);

    // Halted request completes once the halt drops
    model_csr(addr_mepc, op_write, 32'hcafe_f00d);
    send_csr(addr_mepc, op_write, 32'hcafe_f00d);
    halt_i <= 1'b1;
    repeat (3) @(posedge clk);
    halt_i <= 1'b0;
    drain();

    // Trap and CSR request reach writeback together
    model_trap(trap_exception, 31'd7, 32'h0000_0a00);
    model_csr(addr_mepc, op_read, 32'h0);
    @(posedge clk);
    trap_valid_i <= 1'b1;
    trap_i <= trap_req_t'({trap_exception, 31'd7, 32'h0000_0a00});
    csr_req_valid_i <= 1'b1;
    csr_req_i <= csr_req_t'({addr_mepc, op_read, 32'h0});
    do @(posedge clk); while (!(csr_req_ready_o && trap_ready_o));
    trap_valid_i <= 1'b0;
    csr_req_valid_i <= 1'b0;
    drain();

    repeat (200) begin
      rnd = $random(seed);
      if (rnd[3:0] == 4'd0) begin
        do_trap((rnd[5:4] == 2'd3) ? 2'd0 : rnd[5:4], {26'h0, rnd[10:6]}, $random(seed));
      end else begin
        do_csr(addr_tab[rnd[6:4]], rnd[8:7], $random(seed));
      end
    end
    read_all();

    $display("errors: %0d mismatches, %0d other failures", mism_cnt, other_cnt);
    if (mism_cnt == 0 && other_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
hw/csr_pkg.sv
hw/csr_wb_stage.sv
hw/csr_trap_ctrl.sv
hw/csr_regfile.sv
hw/csr_unit.sv
bench/csr_unit_chk.sv
bench/csr_unit_tb.sv

//--- run.sh
#!/bin/sh
# Builds the simulation with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module csr_unit_tb -o csr_unit_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/csr_unit_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TESTS PASSED"; then
  exit 0
fi
exit 1
